// ==== design/pmu_core_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module pmu_core_ctrl #(
    parameter int unsigned WAKE_DELAY = 4
) (
    input  logic                   clk_i,
    input  logic                   rst_ni,

    input  pmu_pkg::power_config_t power_config_i,
    input  logic                   pm_enable_i,

    input  logic                   core_idle_i,
    input  logic                   wake_i,

    output pmu_pkg::pmu_state_e    state_o,
    output logic                   core_clk_en_o,
    output logic                   cache_clk_en_o,
    output logic                   core_pwr_en_o,
    output logic                   retention_o
);

    import pmu_pkg::*;

    localparam int unsigned WCNT_W = (WAKE_DELAY > 1) ? $clog2(WAKE_DELAY) : 1;

    typedef logic [WCNT_W-1:0] wcnt_t;

    // Last cycle spent in PMU_WAKE
    localparam wcnt_t WCNT_LAST = wcnt_t'((WAKE_DELAY > 0) ? WAKE_DELAY - 1 : 0);

    typedef struct packed {
        logic core_clk_en;
        logic cache_clk_en;
        logic core_pwr_en;
        logic retention;
    } gate_t;

    localparam gate_t GATE_ON = '{
        core_clk_en:  1'b1,
        cache_clk_en: 1'b1,
        core_pwr_en:  1'b1,
        retention:    1'b0
    };

    pmu_state_e state_q;
    pmu_state_e state_d;
    timeout_t   cnt_q;        // Idle count, then sleep count
    timeout_t   cnt_d;
    timeout_t   cnt_inc;
    timeout_t   idle_thresh;
    wcnt_t      wcnt_q;
    wcnt_t      wcnt_d;
    gate_t      gate_q;
    gate_t      gate_d;
    logic       stay_idle;

    function automatic gate_t decode_gate(pmu_state_e st, power_config_t cfg);
        gate_t g;
        g = GATE_ON;
        case (st)
            PMU_LIGHT: begin
                g.core_clk_en  = 1'b0;
                g.cache_clk_en = ~cfg.cache_gating_en;
            end
            PMU_SLEEP: begin
                g.core_clk_en  = 1'b0;
                g.cache_clk_en = 1'b0;
                g.core_pwr_en  = 1'b0;
                g.retention    = cfg.retention_mode;
            end
            PMU_WAKE: begin
                // Power is back, clocks wait for the delay
                g.core_clk_en  = 1'b0;
                g.cache_clk_en = 1'b0;
            end
            default: begin
                g = GATE_ON;
            end
        endcase
        return g;
    endfunction

    // Any non-idle cycle, wake or disable counts as activity
    assign stay_idle = pm_enable_i & core_idle_i & ~wake_i;

    assign idle_thresh = power_config_i.aggressive_gating ? timeout_t'(1)
                                                          : power_config_i.idle_timeout;
    assign cnt_inc     = cnt_q + timeout_t'(1);

    always_comb begin
        state_d = state_q;
        cnt_d   = cnt_q;
        wcnt_d  = wcnt_q;
        case (state_q)
            PMU_ACTIVE: begin
                if (!stay_idle) begin
                    cnt_d = '0;
                end else if (cnt_inc >= idle_thresh) begin
                    state_d = PMU_LIGHT;
                    cnt_d   = '0;   // Reused as sleep count
                end else begin
                    cnt_d = cnt_inc;
                end
            end
            PMU_LIGHT: begin
                if (!stay_idle) begin
                    state_d = PMU_ACTIVE;
                    cnt_d   = '0;
                end else if (cnt_inc >= power_config_i.sleep_timeout) begin
                    // Without power gating the count parks here
                    if (power_config_i.power_gating_en) begin
                        state_d = PMU_SLEEP;
                        cnt_d   = '0;
                    end
                end else begin
                    cnt_d = cnt_inc;
                end
            end
            PMU_SLEEP: begin
                if (!stay_idle) begin
                    state_d = PMU_WAKE;
                    wcnt_d  = '0;
                end
            end
            PMU_WAKE: begin
                if (wcnt_q == WCNT_LAST) begin
                    state_d = PMU_ACTIVE;
                    wcnt_d  = '0;
                end else begin
                    wcnt_d = wcnt_q + wcnt_t'(1);
                end
            end
            default: begin
                state_d = PMU_ACTIVE;
                cnt_d   = '0;
                wcnt_d  = '0;
            end
        endcase
    end

    // Outputs follow the next state so they switch with it
    assign gate_d = decode_gate(state_d, power_config_i);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= PMU_ACTIVE;
            cnt_q   <= '0;
            wcnt_q  <= '0;
            gate_q  <= GATE_ON;
        end else begin
            state_q <= state_d;
            cnt_q   <= cnt_d;
            wcnt_q  <= wcnt_d;
            gate_q  <= gate_d;
        end
    end

    assign state_o        = state_q;
    assign core_clk_en_o  = gate_q.core_clk_en;
    assign cache_clk_en_o = gate_q.cache_clk_en;
    assign core_pwr_en_o  = gate_q.core_pwr_en;
    assign retention_o    = gate_q.retention;

endmodule

`default_nettype wire

// ==== design/pmu_csr.sv ====
`timescale 1ns/1ps
`default_nettype none

module pmu_csr #(
    parameter int unsigned NUM_CORES = 1
) (
    input  logic                                         clk_i,
    input  logic                                         rst_ni,

    input  logic                                         csr_access_i,
    input  pmu_pkg::csr_addr_t                           csr_addr_i,
    input  logic                                         csr_write_i,
    input  pmu_pkg::csr_data_t                           csr_wdata_i,
    output pmu_pkg::csr_data_t                           csr_rdata_o,

    input  logic [pmu_pkg::PMU_STATE_W*NUM_CORES-1:0]    core_state_i,

    output pmu_pkg::power_config_t                       power_config_o,
    output logic                                         pm_enable_o
);

    import pmu_pkg::*;

    power_config_t cfg_q;
    logic          pm_enable_q;
    logic          csr_we;
    csr_data_t     cfg_word;
    csr_data_t     status_word;

    assign csr_we = csr_access_i & csr_write_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pm_enable_q             <= 1'b0;
            cfg_q.aggressive_gating <= 1'b0;
            cfg_q.cache_gating_en   <= 1'b0;
            cfg_q.retention_mode    <= 1'b0;
            cfg_q.power_gating_en   <= 1'b0;
            cfg_q.idle_timeout      <= DEFAULT_IDLE_TIMEOUT;
            cfg_q.sleep_timeout     <= DEFAULT_SLEEP_TIMEOUT;
        end else if (csr_we) begin
            case (csr_addr_i)
                PMU_ENABLE_ADDR: begin
                    pm_enable_q <= csr_wdata_i[0];
                end
                PMU_CONFIG_ADDR: begin
                    cfg_q.aggressive_gating <= csr_wdata_i[CFG_AGGRESSIVE_BIT];
                    cfg_q.cache_gating_en   <= csr_wdata_i[CFG_CACHE_GATE_BIT];
                    cfg_q.retention_mode    <= csr_wdata_i[CFG_RETENTION_BIT];
                    cfg_q.power_gating_en   <= csr_wdata_i[CFG_PWR_GATE_BIT];
                end
                PMU_IDLE_TIMEOUT_ADDR: begin
                    cfg_q.idle_timeout <= timeout_t'(csr_wdata_i);
                end
                PMU_SLEEP_TIMEOUT_ADDR: begin
                    cfg_q.sleep_timeout <= timeout_t'(csr_wdata_i);
                end
                default: begin
                    // Status and unmapped addresses drop the write
                end
            endcase
        end
    end

    always_comb begin
        cfg_word                     = '0;
        cfg_word[CFG_AGGRESSIVE_BIT] = cfg_q.aggressive_gating;
        cfg_word[CFG_CACHE_GATE_BIT] = cfg_q.cache_gating_en;
        cfg_word[CFG_RETENTION_BIT]  = cfg_q.retention_mode;
        cfg_word[CFG_PWR_GATE_BIT]   = cfg_q.power_gating_en;
    end

    // Two bits per core from bit 0 up, zero above
    assign status_word = csr_data_t'(core_state_i);

    always_comb begin
        csr_rdata_o = '0;
        if (csr_access_i) begin
            case (csr_addr_i)
                PMU_ENABLE_ADDR:        csr_rdata_o = {31'b0, pm_enable_q};
                PMU_CONFIG_ADDR:        csr_rdata_o = cfg_word;
                PMU_IDLE_TIMEOUT_ADDR:  csr_rdata_o = csr_data_t'(cfg_q.idle_timeout);
                PMU_SLEEP_TIMEOUT_ADDR: csr_rdata_o = csr_data_t'(cfg_q.sleep_timeout);
                PMU_STATUS_ADDR:        csr_rdata_o = status_word;
                default:                csr_rdata_o = '0;
            endcase
        end
    end

    // Registered values go straight out
    assign power_config_o = cfg_q;
    assign pm_enable_o    = pm_enable_q;

endmodule

`default_nettype wire

// ==== design/pmu_pkg.sv ====
`default_nettype none

package pmu_pkg;

    localparam int unsigned CSR_ADDR_W  = 12;
    localparam int unsigned CSR_DATA_W  = 32;
    localparam int unsigned TIMEOUT_W   = 32;
    localparam int unsigned PMU_STATE_W = 2;

    typedef logic [CSR_ADDR_W-1:0] csr_addr_t;
    typedef logic [CSR_DATA_W-1:0] csr_data_t;
    typedef logic [TIMEOUT_W-1:0]  timeout_t;

    // Custom machine-mode CSR window
    localparam csr_addr_t PMU_ENABLE_ADDR        = 12'h7C0;
    localparam csr_addr_t PMU_CONFIG_ADDR        = 12'h7C1;
    localparam csr_addr_t PMU_IDLE_TIMEOUT_ADDR  = 12'h7C2;
    localparam csr_addr_t PMU_SLEEP_TIMEOUT_ADDR = 12'h7C3;
    localparam csr_addr_t PMU_STATUS_ADDR        = 12'h7C4;  // Read only

    // Cycles
    localparam timeout_t DEFAULT_IDLE_TIMEOUT  = 32'd16;
    localparam timeout_t DEFAULT_SLEEP_TIMEOUT = 32'd64;

    // Bit positions in the configuration word
    localparam int unsigned CFG_AGGRESSIVE_BIT = 0;
    localparam int unsigned CFG_CACHE_GATE_BIT = 1;
    localparam int unsigned CFG_RETENTION_BIT  = 2;
    localparam int unsigned CFG_PWR_GATE_BIT   = 3;

    typedef struct packed {
        logic     aggressive_gating;  // Gate after one idle cycle
        logic     cache_gating_en;
        logic     retention_mode;
        logic     power_gating_en;
        timeout_t idle_timeout;
        timeout_t sleep_timeout;
    } power_config_t;

    // Per-core power state, also reported in the status word
    typedef enum logic [PMU_STATE_W-1:0] {
        PMU_ACTIVE = 2'd0,
        PMU_LIGHT  = 2'd1,
        PMU_SLEEP  = 2'd2,
        PMU_WAKE   = 2'd3
    } pmu_state_e;

endpackage

`default_nettype wire

// ==== design/pmu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module pmu_top #(
    parameter int unsigned NUM_CORES  = 2,
    parameter int unsigned WAKE_DELAY = 4
) (
    input  logic                  clk_i,
    input  logic                  rst_ni,

    // CSR port, single cycle
    input  logic                  csr_access_i,
    input  pmu_pkg::csr_addr_t    csr_addr_i,
    input  logic                  csr_write_i,
    input  pmu_pkg::csr_data_t    csr_wdata_i,
    output pmu_pkg::csr_data_t    csr_rdata_o,

    input  logic [NUM_CORES-1:0]  core_idle_i,
    input  logic [NUM_CORES-1:0]  wake_i,
    output logic [NUM_CORES-1:0]  core_clk_en_o,
    output logic [NUM_CORES-1:0]  cache_clk_en_o,
    output logic [NUM_CORES-1:0]  core_pwr_en_o,
    output logic [NUM_CORES-1:0]  retention_o
);

    import pmu_pkg::*;

    power_config_t                          power_config;
    logic                                   pm_enable;
    pmu_state_e                             core_state [NUM_CORES];
    logic [PMU_STATE_W*NUM_CORES-1:0]       core_state_vec;

    pmu_csr #(
        .NUM_CORES      (NUM_CORES)
    ) u_csr (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .csr_access_i   (csr_access_i),
        .csr_addr_i     (csr_addr_i),
        .csr_write_i    (csr_write_i),
        .csr_wdata_i    (csr_wdata_i),
        .csr_rdata_o    (csr_rdata_o),
        .core_state_i   (core_state_vec),
        .power_config_o (power_config),
        .pm_enable_o    (pm_enable)
    );

    for (genvar g = 0; g < NUM_CORES; g++) begin : gen_core
        pmu_core_ctrl #(
            .WAKE_DELAY     (WAKE_DELAY)
        ) u_core (
            .clk_i          (clk_i),
            .rst_ni         (rst_ni),
            .power_config_i (power_config),
            .pm_enable_i    (pm_enable),
            .core_idle_i    (core_idle_i[g]),
            .wake_i         (wake_i[g]),
            .state_o        (core_state[g]),
            .core_clk_en_o  (core_clk_en_o[g]),
            .cache_clk_en_o (cache_clk_en_o[g]),
            .core_pwr_en_o  (core_pwr_en_o[g]),
            .retention_o    (retention_o[g])
        );

        assign core_state_vec[PMU_STATE_W*g +: PMU_STATE_W] = core_state[g];  // Status packing
    end

endmodule

`default_nettype wire

// ==== pmu_top.f ====
design/pmu_pkg.sv
design/pmu_csr.sv
design/pmu_core_ctrl.sv
design/pmu_top.sv
verification/pmu_props.sv
verification/pmu_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the PMU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f pmu_top.f \
    --top-module pmu_tb \
    -Mdir obj_dir \
    -o Vpmu_tb
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build returned status $build_status"
    exit 1
fi

sim_out=$(./obj_dir/Vpmu_tb)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation binary returned status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "Simulation completed successfully"; then
    exit 0
else
    echo "Pass message not found in the output"
    exit 1
fi

// ==== verification/pmu_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module pmu_props (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  pmu_pkg::pmu_state_e state_i,
    input  logic                core_clk_en_i,
    input  logic                core_pwr_en_i,
    input  logic                retention_i
);

    import pmu_pkg::*;

    // No clock on an unpowered core
    a_clk_needs_pwr: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !core_pwr_en_i |-> !core_clk_en_i)
        else $error("core_clk_en high while core_pwr_en is low");

    a_ret_only_off: assert property (@(posedge clk_i) disable iff (!rst_ni)
        retention_i |-> !core_pwr_en_i)
        else $error("retention high while core_pwr_en is high");

    // Wake always finishes through active
    a_wake_not_sleep: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (state_i == PMU_WAKE) |=> (state_i != PMU_SLEEP))
        else $error("state moved from PMU_WAKE straight to PMU_SLEEP");

endmodule

bind pmu_core_ctrl pmu_props u_props (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .state_i       (state_o),
    .core_clk_en_i (core_clk_en_o),
    .core_pwr_en_i (core_pwr_en_o),
    .retention_i   (retention_o)
);

`default_nettype wire

// ==== verification/pmu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module pmu_tb;

    import pmu_pkg::*;

    localparam int unsigned NUM_CORES   = 2;
    localparam int unsigned WAKE_DELAY  = 4;
    localparam int          CLK_PERIOD  = 40;
    localparam int          WATCHDOG_NS = 20_000;  // About 160 cycles of tests, with margin
    localparam int unsigned SEED        = 32'ha6bb_74be;

    localparam int SEL_CLK   = 0;
    localparam int SEL_CACHE = 1;
    localparam int SEL_PWR   = 2;

    typedef logic [$clog2(NUM_CORES)-1:0] core_idx_t;

    logic                 clk_i;
    logic                 rst_ni;
    logic                 csr_access_i;
    csr_addr_t            csr_addr_i;
    logic                 csr_write_i;
    csr_data_t            csr_wdata_i;
    csr_data_t            csr_rdata_o;
    logic [NUM_CORES-1:0] core_idle_i;
    logic [NUM_CORES-1:0] wake_i;
    logic [NUM_CORES-1:0] core_clk_en_o;
    logic [NUM_CORES-1:0] cache_clk_en_o;
    logic [NUM_CORES-1:0] core_pwr_en_o;
    logic [NUM_CORES-1:0] retention_o;

    int errors;
    int checks;

    pmu_top #(
        .NUM_CORES      (NUM_CORES),
        .WAKE_DELAY     (WAKE_DELAY)
    ) u_dut (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .csr_access_i   (csr_access_i),
        .csr_addr_i     (csr_addr_i),
        .csr_write_i    (csr_write_i),
        .csr_wdata_i    (csr_wdata_i),
        .csr_rdata_o    (csr_rdata_o),
        .core_idle_i    (core_idle_i),
        .wake_i         (wake_i),
        .core_clk_en_o  (core_clk_en_o),
        .cache_clk_en_o (cache_clk_en_o),
        .core_pwr_en_o  (core_pwr_en_o),
        .retention_o    (retention_o)
    );

    always #(CLK_PERIOD/2) clk_i = ~clk_i;

    task automatic expect_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAIL t=%0t %s expected=0x%0h actual=0x%0h", $time, name, exp, act);
        end
    endtask

    // Called on a falling edge, returns on the next one
    task automatic write_csr(input csr_addr_t addr, input csr_data_t data);
        csr_access_i = 1'b1;
        csr_write_i  = 1'b1;
        csr_addr_i   = addr;
        csr_wdata_i  = data;
        @(negedge clk_i);
        csr_access_i = 1'b0;
        csr_write_i  = 1'b0;
    endtask

    task automatic read_csr(input csr_addr_t addr, output csr_data_t data);
        csr_access_i = 1'b1;
        csr_write_i  = 1'b0;
        csr_addr_i   = addr;
        #(CLK_PERIOD/4);
        data = csr_rdata_o;  // Combinational, settled mid cycle
        @(negedge clk_i);
        csr_access_i = 1'b0;
    endtask

    task automatic check_csr(input string name, input csr_addr_t addr, input csr_data_t exp);
        csr_data_t rdata;
        read_csr(addr, rdata);
        expect_eq(name, exp, rdata);
    endtask

    function automatic logic pick_output(input core_idx_t core, input int sel);
        logic v;
        case (sel)
            SEL_CLK:   v = core_clk_en_o[core];
            SEL_CACHE: v = cache_clk_en_o[core];
            SEL_PWR:   v = core_pwr_en_o[core];
            default:   v = retention_o[core];
        endcase
        return v;
    endfunction

    // Rising edges until the chosen output reaches level
    task automatic count_edges(input core_idx_t core, input int sel, input logic level,
                               input int limit, output int edges);
        edges = 0;
        while (pick_output(core, sel) !== level && edges < limit) begin
            @(negedge clk_i);
            edges++;
        end
        if (pick_output(core, sel) !== level) begin
            errors++;
            $display("Error at %0t: output %0d of core %0d never reached %b in %0d cycles",
                     $time, sel, core, level, limit);
        end
    endtask

    task automatic reset_values();
        check_csr("enable", PMU_ENABLE_ADDR, 32'h0);
        check_csr("config", PMU_CONFIG_ADDR, 32'h0);
        check_csr("idle_timeout", PMU_IDLE_TIMEOUT_ADDR, 32'd16);
        check_csr("sleep_timeout", PMU_SLEEP_TIMEOUT_ADDR, 32'd64);
        check_csr("status", PMU_STATUS_ADDR, 32'h0);
        expect_eq("core_clk_en_o", 32'h3, 32'(core_clk_en_o));
        expect_eq("cache_clk_en_o", 32'h3, 32'(cache_clk_en_o));
        expect_eq("core_pwr_en_o", 32'h3, 32'(core_pwr_en_o));
        expect_eq("retention_o", 32'h0, 32'(retention_o));
    endtask

    task automatic register_access();
        csr_data_t wdata;
        wdata = $urandom;
        write_csr(PMU_ENABLE_ADDR, wdata);
        check_csr("enable", PMU_ENABLE_ADDR, wdata & 32'h1);
        wdata = $urandom;
        write_csr(PMU_CONFIG_ADDR, wdata);
        check_csr("config", PMU_CONFIG_ADDR, wdata & 32'hF);
        wdata = $urandom;
        write_csr(PMU_IDLE_TIMEOUT_ADDR, wdata);
        check_csr("idle_timeout", PMU_IDLE_TIMEOUT_ADDR, wdata);
        wdata = $urandom;
        write_csr(PMU_SLEEP_TIMEOUT_ADDR, wdata);
        check_csr("sleep_timeout", PMU_SLEEP_TIMEOUT_ADDR, wdata);
        wdata = $urandom;
        write_csr(PMU_STATUS_ADDR, wdata);
        check_csr("status", PMU_STATUS_ADDR, 32'h0);  // Both cores idle low, so active
        write_csr(12'h7C5, wdata);
        check_csr("unmapped 0x7C5", 12'h7C5, 32'h0);
        csr_addr_i = PMU_IDLE_TIMEOUT_ADDR;
        #(CLK_PERIOD/4);
        expect_eq("csr_rdata_o without access", 32'h0, csr_rdata_o);
        @(negedge clk_i);
    endtask

    task automatic disabled_pmu();
        write_csr(PMU_ENABLE_ADDR, 32'h0);
        write_csr(PMU_IDLE_TIMEOUT_ADDR, 32'd5);
        core_idle_i = 2'b11;
        for (int i = 0; i < 100; i++) begin
            @(negedge clk_i);
            expect_eq("core_clk_en_o", 32'h3, 32'(core_clk_en_o));
            expect_eq("cache_clk_en_o", 32'h3, 32'(cache_clk_en_o));
            expect_eq("core_pwr_en_o", 32'h3, 32'(core_pwr_en_o));
        end
        core_idle_i = 2'b00;
        @(negedge clk_i);
    endtask

    task automatic idle_gating_wake();
        int edges;
        write_csr(PMU_CONFIG_ADDR, 32'h0);
        write_csr(PMU_IDLE_TIMEOUT_ADDR, 32'd5);
        write_csr(PMU_ENABLE_ADDR, 32'h1);
        core_idle_i[0] = 1'b1;
        count_edges(1'b0, SEL_CLK, 1'b0, 50, edges);
        expect_eq("edges to core_clk_en_o[0] low", 32'd5, edges);
        expect_eq("core_clk_en_o[1]", 32'h1, 32'(core_clk_en_o[1]));
        expect_eq("cache_clk_en_o[0]", 32'h1, 32'(cache_clk_en_o[0]));
        check_csr("status in light", PMU_STATUS_ADDR, 32'h1);
        core_idle_i[0] = 1'b0;
        @(negedge clk_i);
        expect_eq("core_clk_en_o[0] after idle low", 32'h1, 32'(core_clk_en_o[0]));
        check_csr("status after idle low", PMU_STATUS_ADDR, 32'h0);
    endtask

    task automatic sleep_retention();
        int edges;
        write_csr(PMU_SLEEP_TIMEOUT_ADDR, 32'd3);
        write_csr(PMU_CONFIG_ADDR, 32'hC);  // Power gating and retention
        core_idle_i[0] = 1'b1;
        count_edges(1'b0, SEL_PWR, 1'b0, 50, edges);
        expect_eq("edges to core_pwr_en_o[0] low", 32'd8, edges);
        expect_eq("retention_o[0]", 32'h1, 32'(retention_o[0]));
        expect_eq("core_clk_en_o[0] in sleep", 32'h0, 32'(core_clk_en_o[0]));
        expect_eq("cache_clk_en_o[0] in sleep", 32'h0, 32'(cache_clk_en_o[0]));
        check_csr("status in sleep", PMU_STATUS_ADDR, 32'h2);
        wake_i[0]      = 1'b1;
        core_idle_i[0] = 1'b0;
        @(negedge clk_i);
        wake_i[0] = 1'b0;
        expect_eq("core_pwr_en_o[0] after wake", 32'h1, 32'(core_pwr_en_o[0]));
        expect_eq("retention_o[0] after wake", 32'h0, 32'(retention_o[0]));
        expect_eq("core_clk_en_o[0] after wake", 32'h0, 32'(core_clk_en_o[0]));
        count_edges(1'b0, SEL_CLK, 1'b1, 20, edges);
        expect_eq("edges to core_clk_en_o[0] high", WAKE_DELAY, edges);
    endtask

    task automatic aggressive_cache_gating();
        int edges;
        write_csr(PMU_CONFIG_ADDR, 32'h3);
        core_idle_i[1] = 1'b1;
        count_edges(1'b1, SEL_CLK, 1'b0, 20, edges);
        expect_eq("edges to core_clk_en_o[1] low", 32'd1, edges);
        expect_eq("cache_clk_en_o[1] gated", 32'h0, 32'(cache_clk_en_o[1]));
        core_idle_i[1] = 1'b0;
        @(negedge clk_i);
        expect_eq("core_clk_en_o[1] restored", 32'h1, 32'(core_clk_en_o[1]));
        expect_eq("cache_clk_en_o[1] restored", 32'h1, 32'(cache_clk_en_o[1]));
        write_csr(PMU_CONFIG_ADDR, 32'h1);  // Aggressive only
        core_idle_i[1] = 1'b1;
        count_edges(1'b1, SEL_CLK, 1'b0, 20, edges);
        expect_eq("edges to core_clk_en_o[1] low", 32'd1, edges);
        expect_eq("cache_clk_en_o[1] kept on", 32'h1, 32'(cache_clk_en_o[1]));
        core_idle_i[1] = 1'b0;
        @(negedge clk_i);
    endtask

    initial begin
        errors       = 0;
        checks       = 0;
        clk_i        = 1'b0;
        rst_ni       = 1'b0;
        csr_access_i = 1'b0;
        csr_write_i  = 1'b0;
        csr_addr_i   = '0;
        csr_wdata_i  = '0;
        core_idle_i  = '0;
        wake_i       = '0;
        void'($urandom(SEED));
        repeat (2) @(negedge clk_i);
        rst_ni = 1'b1;
        reset_values();
        register_access();
        disabled_pmu();
        idle_gating_wake();
        sleep_retention();
        aggressive_cache_gating();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #WATCHDOG_NS;
        $display("Timeout: tests still running after %0d ns", WATCHDOG_NS);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire
